//--- verilog/valu_pkg.sv
/*
 * Lane ALU widths, opcode values, stage word types
 * and the restoring division step
 */
`default_nettype none

package valu_pkg;

    localparam int DATA_W        = 32;
    localparam int MICROOP_W     = 7;
    localparam int DIV_STAGES    = 4;
    localparam int DIV_STEP_BITS = DATA_W / DIV_STAGES;

    // ------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------
    localparam logic [MICROOP_W-1:0] OP_VADD  = 7'b0000001;
    localparam logic [MICROOP_W-1:0] OP_VADDI = 7'b0000010;
    localparam logic [MICROOP_W-1:0] OP_VSUB  = 7'b0000101;
    localparam logic [MICROOP_W-1:0] OP_VDIV  = 7'b0001100;
    localparam logic [MICROOP_W-1:0] OP_VDIVU = 7'b0001101;
    localparam logic [MICROOP_W-1:0] OP_VREM  = 7'b0001110;
    localparam logic [MICROOP_W-1:0] OP_VREMU = 7'b0001111;
    localparam logic [MICROOP_W-1:0] OP_VSLL  = 7'b0010000;
    localparam logic [MICROOP_W-1:0] OP_VSRA  = 7'b0010010;
    localparam logic [MICROOP_W-1:0] OP_VSRL  = 7'b0010100;
    localparam logic [MICROOP_W-1:0] OP_VAND  = 7'b0010110;
    localparam logic [MICROOP_W-1:0] OP_VANDI = 7'b0010111;
    localparam logic [MICROOP_W-1:0] OP_VOR   = 7'b0011000;
    localparam logic [MICROOP_W-1:0] OP_VORI  = 7'b0011001;
    localparam logic [MICROOP_W-1:0] OP_VXOR  = 7'b0011010;
    localparam logic [MICROOP_W-1:0] OP_VXORI = 7'b0011011;
    localparam logic [MICROOP_W-1:0] OP_VSEQ  = 7'b0011100;
    localparam logic [MICROOP_W-1:0] OP_VSLT  = 7'b0011101;
    localparam logic [MICROOP_W-1:0] OP_VSLTU = 7'b0011110;

    // ------------------------------------------------------------
    // Stage word
    // ------------------------------------------------------------
    typedef struct packed {
        logic [DATA_W-1:0] quot;
        logic [DATA_W-1:0] rem;
        logic [DATA_W-1:0] dvs;
    } div_state_t;

    // View picked by is_div
    typedef union packed {
        div_state_t dstate;
        struct packed {
            logic [2*DATA_W-1:0] pad;
            logic [DATA_W-1:0]   res;
        } ival;
    } stage_word_u;

    // One group of restoring steps, dividend bits shift out of quot
    function automatic div_state_t div_step(input div_state_t st_in);
        div_state_t      st;
        logic [DATA_W:0] shifted;
        int              i;
        st = st_in;
        for (i = 0; i < DIV_STEP_BITS; i++) begin
            shifted = {st.rem, st.quot[DATA_W-1]};
            st.quot = {st.quot[DATA_W-2:0], 1'b0};
            if (shifted >= {1'b0, st.dvs}) begin
                st.quot[0] = 1'b1;
                shifted    = shifted - {1'b0, st.dvs};
            end
            st.rem = shifted[DATA_W-1:0];
        end
        return st;
    endfunction

endpackage

`default_nettype wire

//--- verilog/valu_stage_if.sv
/* Stage interface for one in-flight lane operation */
`default_nettype none
`timescale 1ns/100ps

interface valu_stage_if import valu_pkg::*; ();

    logic        valid;
    logic        is_div;
    logic        is_rem;
    // Sign fixups applied at writeback
    logic        neg_quot;
    logic        neg_rem;
    stage_word_u word;

    modport src (
        output valid, is_div, is_rem, neg_quot, neg_rem, word
    );

    modport dst (
        input valid, is_div, is_rem, neg_quot, neg_rem, word
    );

endinterface

`default_nettype wire

//--- verilog/valu_issue.sv
/*
 * Issue stage: opcode decode, integer results,
 * division operand setup and first quotient group
 */
`default_nettype none
`timescale 1ns/100ps

module valu_issue import valu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_i,
    input  logic [MICROOP_W-1:0] microop_i,
    input  logic [DATA_W-1:0]    data_a_i,
    input  logic [DATA_W-1:0]    data_b_i,
    input  logic [DATA_W-1:0]    imm_i,
    valu_stage_if.src            issue_q
);

    logic              known_op;
    logic              is_div;
    logic              is_rem;
    logic              sign_div;
    logic [4:0]        shamt;
    logic [DATA_W-1:0] int_res;
    logic [DATA_W-1:0] a_mag;
    logic [DATA_W-1:0] b_mag;
    div_state_t        div_init;
    stage_word_u       word_d;

    assign shamt = data_b_i[4:0];

    // ------------------------------------------------------------
    // Decode and integer group
    // ------------------------------------------------------------
    always_comb begin
        known_op = 1'b1;
        is_div   = 1'b0;
        is_rem   = 1'b0;
        sign_div = 1'b0;
        int_res  = '0;
        case (microop_i)
            OP_VADD:  int_res = data_a_i + data_b_i;
            OP_VADDI: int_res = data_a_i + imm_i;
            OP_VSUB:  int_res = data_a_i - data_b_i;
            OP_VSLL:  int_res = data_a_i << shamt;
            OP_VSRL:  int_res = data_a_i >> shamt;
            OP_VSRA:  int_res = $signed(data_a_i) >>> shamt;
            OP_VAND:  int_res = data_a_i & data_b_i;
            OP_VANDI: int_res = data_a_i & imm_i;
            OP_VOR:   int_res = data_a_i | data_b_i;
            OP_VORI:  int_res = data_a_i | imm_i;
            OP_VXOR:  int_res = data_a_i ^ data_b_i;
            OP_VXORI: int_res = data_a_i ^ imm_i;
            OP_VSEQ:  int_res = {{(DATA_W-1){1'b0}}, data_a_i == data_b_i};
            OP_VSLT:  int_res = {{(DATA_W-1){1'b0}}, $signed(data_a_i) < $signed(data_b_i)};
            OP_VSLTU: int_res = {{(DATA_W-1){1'b0}}, data_a_i < data_b_i};
            OP_VDIV, OP_VDIVU, OP_VREM, OP_VREMU: begin
                is_div   = 1'b1;
                is_rem   = (microop_i == OP_VREM) || (microop_i == OP_VREMU);
                sign_div = (microop_i == OP_VDIV) || (microop_i == OP_VREM);
            end
            default:  known_op = 1'b0;
        endcase
    end

    // Divider works on magnitudes
    assign a_mag    = (sign_div && data_a_i[DATA_W-1]) ? -data_a_i : data_a_i;
    assign b_mag    = (sign_div && data_b_i[DATA_W-1]) ? -data_b_i : data_b_i;
    assign div_init = '{quot: a_mag, rem: '0, dvs: b_mag};

    always_comb begin
        if (is_div) begin
            word_d.dstate = div_step(div_init);
        end else begin
            word_d.ival.pad = '0;
            word_d.ival.res = int_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q.valid <= 1'b0;
        end else begin
            issue_q.valid <= valid_i & known_op;
        end
    end

    always_ff @(posedge clk) begin
        issue_q.is_div   <= is_div;
        issue_q.is_rem   <= is_rem;
        issue_q.neg_quot <= sign_div & (data_a_i[DATA_W-1] ^ data_b_i[DATA_W-1]);
        issue_q.neg_rem  <= sign_div & data_a_i[DATA_W-1];
        issue_q.word     <= word_d;
    end

endmodule

`default_nettype wire

//--- verilog/valu_div_pipe.sv
/*
 * Division groups two to four with their stage registers
 * and pass-through of integer results
 */
`default_nettype none
`timescale 1ns/100ps

module valu_div_pipe import valu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    valu_stage_if.dst stage_in,
    valu_stage_if.src stage_out
);

    // Index 0 after group two, index 1 after group three
    logic        valid_q    [2];
    logic        is_div_q   [2];
    logic        is_rem_q   [2];
    logic        neg_quot_q [2];
    logic        neg_rem_q  [2];
    stage_word_u word_q     [2];

    function automatic stage_word_u advance(input stage_word_u w, input logic is_div);
        stage_word_u nxt;
        nxt = w;
        if (is_div) begin
            nxt.dstate = div_step(w.dstate);
        end
        return nxt;
    endfunction

    // ------------------------------------------------------------
    // Stage registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q[0] <= 1'b0;
            valid_q[1] <= 1'b0;
        end else begin
            valid_q[0] <= stage_in.valid;
            valid_q[1] <= valid_q[0];
        end
    end

    always_ff @(posedge clk) begin
        is_div_q[0]   <= stage_in.is_div;
        is_rem_q[0]   <= stage_in.is_rem;
        neg_quot_q[0] <= stage_in.neg_quot;
        neg_rem_q[0]  <= stage_in.neg_rem;
        word_q[0]     <= advance(stage_in.word, stage_in.is_div);

        is_div_q[1]   <= is_div_q[0];
        is_rem_q[1]   <= is_rem_q[0];
        neg_quot_q[1] <= neg_quot_q[0];
        neg_rem_q[1]  <= neg_rem_q[0];
        word_q[1]     <= advance(word_q[0], is_div_q[0]);
    end

    // Last group is combinational into writeback
    assign stage_out.valid    = valid_q[1];
    assign stage_out.is_div   = is_div_q[1];
    assign stage_out.is_rem   = is_rem_q[1];
    assign stage_out.neg_quot = neg_quot_q[1];
    assign stage_out.neg_rem  = neg_rem_q[1];
    assign stage_out.word     = advance(word_q[1], is_div_q[1]);

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(stage_in.valid) && !$isunknown(stage_out.valid));

endmodule

`default_nettype wire

//--- verilog/valu_writeback.sv
/* Writeback: sign fixup, quotient or remainder pick, result register */
`default_nettype none
`timescale 1ns/100ps

module valu_writeback import valu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    valu_stage_if.dst         stage_in,
    output logic              valid_o,
    output logic [DATA_W-1:0] result_o
);

    div_state_t        st;
    logic [DATA_W-1:0] res_d;

    assign st = stage_in.word.dstate;

    always_comb begin
        if (!stage_in.is_div) begin
            res_d = stage_in.word.ival.res;
        end else if (stage_in.is_rem) begin
            // Remainder follows the dividend sign
            res_d = stage_in.neg_rem ? -st.rem : st.rem;
        end else begin
            res_d = stage_in.neg_quot ? -st.quot : st.quot;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= stage_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        result_o <= res_d;
    end

    a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> !$isunknown(result_o));

endmodule

`default_nettype wire

//--- verilog/valu_top.sv
/* Lane integer unit top: issue, divide pipeline and writeback */
`default_nettype none
`timescale 1ns/100ps

module valu_top import valu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_i,
    input  logic [MICROOP_W-1:0] microop_i,
    input  logic [DATA_W-1:0]    data_a_i,
    input  logic [DATA_W-1:0]    data_b_i,
    input  logic [DATA_W-1:0]    imm_i,
    output logic                 valid_o,
    output logic [DATA_W-1:0]    result_o
);

    valu_stage_if issue_q ();
    valu_stage_if pipe_q ();

    valu_issue u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_i),
        .microop_i (microop_i),
        .data_a_i  (data_a_i),
        .data_b_i  (data_b_i),
        .imm_i     (imm_i),
        .issue_q   (issue_q.src)
    );

    valu_div_pipe u_div_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (issue_q.dst),
        .stage_out (pipe_q.src)
    );

    valu_writeback u_writeback (
        .clk      (clk),
        .rst_n    (rst_n),
        .stage_in (pipe_q.dst),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

//--- testbench/valu_checker.sv
/*
 * Checker for the lane integer unit: reference model,
 * expected-result queue and per-slot compare
 */
`default_nettype none
`timescale 1ns/100ps

module valu_checker import valu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_i,
    input  logic [MICROOP_W-1:0] microop_i,
    input  logic [DATA_W-1:0]    data_a_i,
    input  logic [DATA_W-1:0]    data_b_i,
    input  logic [DATA_W-1:0]    imm_i,
    input  logic                 valid_o,
    input  logic [DATA_W-1:0]    result_o,
    output int                   errors_o,
    output int                   checks_o
);

    // Inputs seen at one falling edge come out four falling edges later
    localparam int LATENCY = 4;

    logic [LATENCY-1:0] slots;
    logic [DATA_W-1:0]  exp_q [$];
    logic [DATA_W-1:0]  expected;
    int                 n_errors = 0;
    int                 n_checks = 0;

    assign errors_o = n_errors;
    assign checks_o = n_checks;

    function automatic logic is_known(input logic [MICROOP_W-1:0] op);
        case (op)
            OP_VADD, OP_VADDI, OP_VSUB, OP_VSLL, OP_VSRL, OP_VSRA, OP_VAND,
            OP_VANDI, OP_VOR, OP_VORI, OP_VXOR, OP_VXORI, OP_VSEQ, OP_VSLT,
            OP_VSLTU, OP_VDIV, OP_VDIVU, OP_VREM, OP_VREMU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic [DATA_W-1:0] ref_result(input logic [MICROOP_W-1:0] op,
                                                     input logic [DATA_W-1:0]    a,
                                                     input logic [DATA_W-1:0]    b,
                                                     input logic [DATA_W-1:0]    imm);
        logic                signed_op;
        logic [DATA_W-1:0]   ua;
        logic [DATA_W-1:0]   ub;
        logic [DATA_W-1:0]   q;
        logic [DATA_W-1:0]   r;
        logic [2*DATA_W-1:0] ext;
        case (op)
            OP_VADD:  return a + b;
            OP_VADDI: return a + imm;
            OP_VSUB:  return a - b;
            OP_VSLL:  return a << b[4:0];
            OP_VSRL:  return a >> b[4:0];
            OP_VSRA: begin
                ext = {{DATA_W{a[DATA_W-1]}}, a} >> b[4:0];
                return ext[DATA_W-1:0];
            end
            OP_VAND:  return a & b;
            OP_VANDI: return a & imm;
            OP_VOR:   return a | b;
            OP_VORI:  return a | imm;
            OP_VXOR:  return a ^ b;
            OP_VXORI: return a ^ imm;
            OP_VSEQ:  return (a == b) ? 32'd1 : 32'd0;
            OP_VSLT: begin
                if (a[DATA_W-1] != b[DATA_W-1]) begin
                    return a[DATA_W-1] ? 32'd1 : 32'd0;
                end
                return (a < b) ? 32'd1 : 32'd0;
            end
            OP_VSLTU: return (a < b) ? 32'd1 : 32'd0;
            default: begin
                // Magnitudes first, signs afterwards
                signed_op = (op == OP_VDIV) || (op == OP_VREM);
                ua = (signed_op && a[DATA_W-1]) ? ~a + 32'd1 : a;
                ub = (signed_op && b[DATA_W-1]) ? ~b + 32'd1 : b;
                if (ub == '0) begin
                    q = '1;
                    r = ua;
                end else begin
                    q = ua / ub;
                    r = ua % ub;
                end
                if (signed_op && (a[DATA_W-1] ^ b[DATA_W-1])) begin
                    q = ~q + 32'd1;
                end
                if (signed_op && a[DATA_W-1]) begin
                    r = ~r + 32'd1;
                end
                return (op == OP_VREM || op == OP_VREMU) ? r : q;
            end
        endcase
    endfunction

    // ------------------------------------------------------------
    // Compare on the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            if (valid_o !== 1'b0) begin
                $display("error: valid_o got %h expected 0 in reset at %0t", valid_o, $time);
                n_errors++;
            end
            slots = '0;
            exp_q.delete();
        end else begin
            if (slots[LATENCY-1]) begin
                expected = exp_q.pop_front();
            end
            if (valid_o !== slots[LATENCY-1]) begin
                $display("error: valid_o got %h expected %h at %0t",
                         valid_o, slots[LATENCY-1], $time);
                n_errors++;
            end else if (valid_o) begin
                n_checks++;
                if (result_o !== expected) begin
                    $display("error: result_o got %08h expected %08h at %0t",
                             result_o, expected, $time);
                    n_errors++;
                end
            end
            if (valid_i === 1'b1 && is_known(microop_i)) begin
                exp_q.push_back(ref_result(microop_i, data_a_i, data_b_i, imm_i));
                slots = {slots[LATENCY-2:0], 1'b1};
            end else begin
                slots = {slots[LATENCY-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_valu.sv
/*
 * Testbench top for the lane integer unit: clock, reset,
 * directed and random stimulus, watchdog
 */
`default_nettype none
`timescale 1ns/100ps

module tb_valu import valu_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 10;
    localparam int DRAIN_CYCLES = 8;
    localparam int N_TESTS      = 5;
    localparam int N_DIRECTED   = 40;
    localparam int N_RANDOM     = 300;
    localparam int N_MIXED      = 120;
    localparam int RUN_CYCLES   = RESET_CYCLES + IDLE_CYCLES + N_DIRECTED + N_RANDOM
                                  + N_MIXED + N_TESTS * DRAIN_CYCLES;
    localparam int N_KEPT       = 19;

    localparam logic [MICROOP_W-1:0] KEPT_OPS [N_KEPT] = '{
        OP_VADD, OP_VADDI, OP_VSUB, OP_VSLL, OP_VSRL, OP_VSRA, OP_VAND,
        OP_VANDI, OP_VOR, OP_VORI, OP_VXOR, OP_VXORI, OP_VSEQ, OP_VSLT,
        OP_VSLTU, OP_VDIV, OP_VDIVU, OP_VREM, OP_VREMU
    };

    logic                 clk;
    logic                 rst_n;
    logic                 valid_i;
    logic [MICROOP_W-1:0] microop_i;
    logic [DATA_W-1:0]    data_a_i;
    logic [DATA_W-1:0]    data_b_i;
    logic [DATA_W-1:0]    imm_i;
    logic                 valid_o;
    logic [DATA_W-1:0]    result_o;
    int                   errors;
    int                   checks;
    int                   issued      = 0;
    int                   test_num    = 0;
    int                   prev_errors = 0;
    int                   prev_checks = 0;

    valu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_i),
        .microop_i (microop_i),
        .data_a_i  (data_a_i),
        .data_b_i  (data_b_i),
        .imm_i     (imm_i),
        .valid_o   (valid_o),
        .result_o  (result_o)
    );

    valu_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_i),
        .microop_i (microop_i),
        .data_a_i  (data_a_i),
        .data_b_i  (data_b_i),
        .imm_i     (imm_i),
        .valid_o   (valid_o),
        .result_o  (result_o),
        .errors_o  (errors),
        .checks_o  (checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic op_is_kept(input logic [MICROOP_W-1:0] op);
        logic found;
        found = 1'b0;
        foreach (KEPT_OPS[i]) begin
            if (KEPT_OPS[i] == op) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic logic [MICROOP_W-1:0] random_kept_op();
        logic [4:0] idx;
        idx = 5'($urandom_range(0, N_KEPT - 1));
        return KEPT_OPS[idx];
    endfunction

    // Small magnitudes often, so quotients are not mostly zero
    function automatic logic [DATA_W-1:0] random_operand();
        logic [DATA_W-1:0] val;
        val = $urandom;
        case ($urandom_range(0, 3))
            0: val = {28'h0000000, val[3:0]};
            1: val = {28'hfffffff, val[3:0]};
            default: ;
        endcase
        return val;
    endfunction

    task automatic issue_op(input logic [MICROOP_W-1:0] op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] imm);
        @(posedge clk);
        valid_i   <= 1'b1;
        microop_i <= op;
        data_a_i  <= a;
        data_b_i  <= b;
        imm_i     <= imm;
        if (op_is_kept(op)) begin
            issued++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        idle_cycles(DRAIN_CYCLES);
        test_num++;
        $display("test %0d %s: %0d results checked, %0d errors", test_num, name,
                 checks - prev_checks, errors - prev_errors);
        prev_checks = checks;
        prev_errors = errors;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        logic [MICROOP_W-1:0] op;
        logic [DATA_W-1:0]    rnd;
        int                   i;
        void'($urandom(32'h451bbd41));
        rst_n     <= 1'b0;
        valid_i   <= 1'b0;
        microop_i <= '0;
        data_a_i  <= '0;
        data_b_i  <= '0;
        imm_i     <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        idle_cycles(IDLE_CYCLES);
        finish_test("reset_idle");

        issue_op(OP_VADD,  32'h7fffffff, 32'h00000001, 32'h0);
        issue_op(OP_VADDI, 32'h12345678, 32'h0, 32'hedcba988);
        issue_op(OP_VSUB,  32'h00000000, 32'h00000001, 32'h0);
        issue_op(OP_VSLL,  32'h00000001, 32'h00000000, 32'h0);
        issue_op(OP_VSLL,  32'h00000003, 32'h0000001f, 32'h0);
        issue_op(OP_VSRL,  32'h80000000, 32'h0000001f, 32'h0);
        issue_op(OP_VSRA,  32'h80000000, 32'h0000001f, 32'h0);
        // Upper shift bits must be ignored
        issue_op(OP_VSRA,  32'hf0000000, 32'hffffffe4, 32'h0);
        issue_op(OP_VAND,  32'hff00ff00, 32'h0ff00ff0, 32'h0);
        issue_op(OP_VANDI, 32'hff00ff00, 32'h0, 32'h0ff00ff0);
        issue_op(OP_VOR,   32'hf0f00000, 32'h00000f0f, 32'h0);
        issue_op(OP_VORI,  32'hf0f00000, 32'h0, 32'h00000f0f);
        issue_op(OP_VXOR,  32'haaaaaaaa, 32'hffff0000, 32'h0);
        issue_op(OP_VXORI, 32'haaaaaaaa, 32'h0, 32'hffff0000);
        issue_op(OP_VSEQ,  32'h13572468, 32'h13572468, 32'h0);
        issue_op(OP_VSLT,  32'hffffffff, 32'h00000001, 32'h0);
        issue_op(OP_VSLTU, 32'hffffffff, 32'h00000001, 32'h0);
        finish_test("directed_int");

        issue_op(OP_VDIV,  32'd100, 32'd7, 32'h0);
        issue_op(OP_VDIV,  32'hffffff9c, 32'd7, 32'h0);
        issue_op(OP_VDIV,  32'd100, 32'hfffffff9, 32'h0);
        issue_op(OP_VDIV,  32'hffffff9c, 32'hfffffff9, 32'h0);
        issue_op(OP_VREM,  32'hffffff9c, 32'd7, 32'h0);
        issue_op(OP_VREM,  32'd100, 32'hfffffff9, 32'h0);
        issue_op(OP_VDIVU, 32'hffffffff, 32'd3, 32'h0);
        issue_op(OP_VREMU, 32'hffffffff, 32'd10, 32'h0);
        issue_op(OP_VDIV,  32'd5, 32'd0, 32'h0);
        issue_op(OP_VDIVU, 32'd5, 32'd0, 32'h0);
        issue_op(OP_VREM,  32'hfffffffb, 32'd0, 32'h0);
        issue_op(OP_VREMU, 32'd9, 32'd0, 32'h0);
        issue_op(OP_VDIV,  32'h80000000, 32'hffffffff, 32'h0);
        issue_op(OP_VREM,  32'h80000000, 32'hffffffff, 32'h0);
        finish_test("directed_div");

        for (i = 0; i < N_RANDOM; i++) begin
            issue_op(random_kept_op(), random_operand(), random_operand(), $urandom);
        end
        finish_test("random_mix");

        // Idle slots, unknown opcodes and real work interleaved
        for (i = 0; i < N_MIXED; i++) begin
            rnd = $urandom;
            op  = rnd[MICROOP_W-1:0];
            case ($urandom_range(0, 3))
                0: begin
                    @(posedge clk);
                    valid_i   <= 1'b0;
                    microop_i <= random_kept_op();
                end
                1: begin
                    while (op_is_kept(op)) begin
                        op = op + 7'd1;
                    end
                    issue_op(op, rnd, ~rnd, rnd);
                end
                default: issue_op(random_kept_op(), random_operand(), random_operand(), rnd);
            endcase
        end
        finish_test("gaps_and_unknown");

        if (checks != issued) begin
            $display("results checked (%0d) do not match operations issued (%0d)",
                     checks, issued);
        end
        $display("total: %0d tests, %0d results checked, %0d errors", test_num, checks, errors);
        if (errors == 0 && checks == issued) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #((RUN_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", RUN_CYCLES + 100);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/valu_pkg.sv
verilog/valu_stage_if.sv
verilog/valu_issue.sv
verilog/valu_div_pipe.sv
verilog/valu_writeback.sv
verilog/valu_top.sv
testbench/valu_checker.sv
testbench/tb_valu.sv

//--- run.sh
#!/bin/sh
# Build and run the lane integer unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_valu -o sim_valu
./obj_dir/sim_valu | tee sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
